// File: src/id_pkg.sv
package id_pkg;

   // Widths that carry a meaning
   typedef logic [31:0] word_t;
   typedef logic [31:2] pc_t;      // Word-aligned PC
   typedef logic [31:2] instr_t;   // Low two bits are always 2'b11
   typedef logic [4:0]  reg_idx_t;
   typedef logic [3:0]  alu_op_t;
   typedef logic [1:0]  wb_sel_t;
   typedef logic [1:0]  br_op_t;

   // Base opcodes, instruction bits 6 to 2
   localparam logic [4:0] OPC_OP     = 5'b01100;
   localparam logic [4:0] OPC_OP_IMM = 5'b00100;
   localparam logic [4:0] OPC_LOAD   = 5'b00000;
   localparam logic [4:0] OPC_STORE  = 5'b01000;
   localparam logic [4:0] OPC_BRANCH = 5'b11000;
   localparam logic [4:0] OPC_LUI    = 5'b01101;
   localparam logic [4:0] OPC_AUIPC  = 5'b00101;
   localparam logic [4:0] OPC_JAL    = 5'b11011;
   localparam logic [4:0] OPC_JALR   = 5'b11001;

   // ALU operations
   localparam alu_op_t ALU_ADD    = 4'd0;
   localparam alu_op_t ALU_SUB    = 4'd1;
   localparam alu_op_t ALU_SLL    = 4'd2;
   localparam alu_op_t ALU_SLT    = 4'd3;
   localparam alu_op_t ALU_SLTU   = 4'd4;
   localparam alu_op_t ALU_XOR    = 4'd5;
   localparam alu_op_t ALU_SRL    = 4'd6;
   localparam alu_op_t ALU_SRA    = 4'd7;
   localparam alu_op_t ALU_OR     = 4'd8;
   localparam alu_op_t ALU_AND    = 4'd9;
   localparam alu_op_t ALU_PASS_B = 4'd10;   // Result is operand 2

   localparam wb_sel_t WB_ALU = 2'd0;
   localparam wb_sel_t WB_MEM = 2'd1;
   localparam wb_sel_t WB_PC4 = 2'd2;   // Link address

   localparam br_op_t BR_NONE = 2'd0;
   localparam br_op_t BR_COND = 2'd1;
   localparam br_op_t BR_JAL  = 2'd2;
   localparam br_op_t BR_JALR = 2'd3;

endpackage

// File: src/id_ctrl_if.sv
`timescale 1ns/1ps

interface id_ctrl_if;
   import id_pkg::*;

   alu_op_t     alu_op;
   logic        op1_sel;   // 1 selects the PC
   logic        op2_sel;   // 1 selects the immediate
   wb_sel_t     wb_sel;
   logic        reg_wr;
   logic        is_load;
   logic        is_store;
   br_op_t      br_op;
   logic [2:0]  funct3;
   word_t       imm;

   // Decoder side
   modport dec (output alu_op, op1_sel, op2_sel, wb_sel, reg_wr,
                output is_load, is_store, br_op, funct3, imm);

   // Pipeline register side
   modport reg_side (input alu_op, op1_sel, op2_sel, wb_sel, reg_wr,
                     input is_load, is_store, br_op, funct3, imm);

endinterface

// File: src/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
   input  id_pkg::instr_t instr_i,
   id_ctrl_if.dec         ctrl
);
   import id_pkg::*;

   logic [4:0] opcode;
   logic [2:0] funct3;
   logic       funct7_b30;

   assign opcode     = instr_i[6:2];
   assign funct3     = instr_i[14:12];
   assign funct7_b30 = instr_i[30];

   // Shared by OP and OP-IMM
   function automatic alu_op_t alu_from_funct(input logic [2:0] f3, input logic alt);
      alu_op_t op;
      case (f3)
         3'b000:  op = alt ? ALU_SUB : ALU_ADD;
         3'b001:  op = ALU_SLL;
         3'b010:  op = ALU_SLT;
         3'b011:  op = ALU_SLTU;
         3'b100:  op = ALU_XOR;
         3'b101:  op = alt ? ALU_SRA : ALU_SRL;
         3'b110:  op = ALU_OR;
         default: op = ALU_AND;
      endcase
      return op;
   endfunction

   always_comb begin
      ctrl.alu_op   = ALU_ADD;
      ctrl.op1_sel  = 1'b0;
      ctrl.op2_sel  = 1'b0;
      ctrl.wb_sel   = WB_ALU;
      ctrl.reg_wr   = 1'b0;
      ctrl.is_load  = 1'b0;
      ctrl.is_store = 1'b0;
      ctrl.br_op    = BR_NONE;
      ctrl.funct3   = funct3;
      ctrl.imm      = '0;

      case (opcode)
         OPC_OP: begin
            ctrl.alu_op = alu_from_funct(funct3, funct7_b30);
            ctrl.reg_wr = 1'b1;
         end
         OPC_OP_IMM: begin
            // Bit 30 only matters for SRAI here
            ctrl.alu_op  = alu_from_funct(funct3, funct7_b30 && (funct3 == 3'b101));
            ctrl.op2_sel = 1'b1;
            ctrl.reg_wr  = 1'b1;
            ctrl.imm     = {{20{instr_i[31]}}, instr_i[31:20]};   // I
         end
         OPC_LOAD: begin
            ctrl.op2_sel = 1'b1;
            ctrl.wb_sel  = WB_MEM;
            ctrl.reg_wr  = 1'b1;
            ctrl.is_load = 1'b1;
            ctrl.imm     = {{20{instr_i[31]}}, instr_i[31:20]};
         end
         OPC_STORE: begin
            ctrl.op2_sel  = 1'b1;
            ctrl.is_store = 1'b1;
            ctrl.imm      = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};   // S
         end
         OPC_BRANCH: begin
            // ALU forms the target, EX compares rs1 and rs2 by funct3
            ctrl.op1_sel = 1'b1;
            ctrl.op2_sel = 1'b1;
            ctrl.br_op   = BR_COND;
            ctrl.imm     = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                            instr_i[30:25], instr_i[11:8], 1'b0};
         end
         OPC_LUI: begin
            ctrl.alu_op  = ALU_PASS_B;
            ctrl.op2_sel = 1'b1;
            ctrl.reg_wr  = 1'b1;
            ctrl.imm     = {instr_i[31:12], 12'b0};   // U
         end
         OPC_AUIPC: begin
            ctrl.op1_sel = 1'b1;
            ctrl.op2_sel = 1'b1;
            ctrl.reg_wr  = 1'b1;
            ctrl.imm     = {instr_i[31:12], 12'b0};
         end
         OPC_JAL: begin
            ctrl.op1_sel = 1'b1;
            ctrl.op2_sel = 1'b1;
            ctrl.wb_sel  = WB_PC4;
            ctrl.reg_wr  = 1'b1;
            ctrl.br_op   = BR_JAL;
            ctrl.imm     = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                            instr_i[20], instr_i[30:21], 1'b0};   // J
         end
         OPC_JALR: begin
            ctrl.op2_sel = 1'b1;
            ctrl.wb_sel  = WB_PC4;
            ctrl.reg_wr  = 1'b1;
            ctrl.br_op   = BR_JALR;
            ctrl.imm     = {{20{instr_i[31]}}, instr_i[31:20]};
         end
         default: ctrl.funct3 = '0;   // Unknown opcode is a no-op
      endcase
   end

endmodule

// File: src/regfile.sv
`timescale 1ns/1ps

module regfile (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  id_pkg::reg_idx_t rs1_idx_i,
   input  id_pkg::reg_idx_t rs2_idx_i,
   input  id_pkg::reg_idx_t rd_wr_idx_i,   // Index 0 means no write
   input  id_pkg::word_t    rd_wr_data_i,
   output id_pkg::word_t    rs1_data_o,
   output id_pkg::word_t    rs2_data_o
);
   import id_pkg::*;

   word_t regs [1:31];   // x0 has no storage

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (rd_wr_idx_i != '0) begin
         regs[rd_wr_idx_i] <= rd_wr_data_i;
      end
   end

   // Write-first read with x0 tied to zero
   function automatic word_t read_port(input reg_idx_t idx);
      word_t data;
      if (idx == '0) begin
         data = '0;
      end else if (idx == rd_wr_idx_i) begin
         data = rd_wr_data_i;   // Same-cycle bypass
      end else begin
         data = regs[idx];
      end
      return data;
   endfunction

   always_comb begin
      rs1_data_o = read_port(rs1_idx_i);
      rs2_data_o = read_port(rs2_idx_i);
   end

endmodule

// File: src/id_ex_register.sv
`timescale 1ns/1ps

module id_ex_register (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               flush_i,
   input  logic               busywait_i,
   input  logic               stall_i,
   id_ctrl_if.reg_side        ctrl,
   input  id_pkg::instr_t     instr_i,
   input  id_pkg::pc_t        pc_i,
   input  id_pkg::word_t      rs1_data_i,
   input  id_pkg::word_t      rs2_data_i,
   output logic               load_stall_o,
   output id_pkg::pc_t        pc_o,
   output id_pkg::word_t      rs1_value_o,
   output id_pkg::word_t      rs2_value_o,
   output id_pkg::word_t      imm_value_o,
   output id_pkg::reg_idx_t   rs1_label_o,
   output id_pkg::reg_idx_t   rs2_label_o,
   output id_pkg::reg_idx_t   rd_o,
   output id_pkg::alu_op_t    alu_op_o,
   output logic               alu_op1_sel_o,
   output logic               alu_op2_sel_o,
   output id_pkg::wb_sel_t    wb_sel_o,
   output logic               reg_wr_o,
   output logic               is_load_o,
   output logic               is_store_o,
   output id_pkg::br_op_t     br_op_o,
   output logic [2:0]         funct3_o
);
   import id_pkg::*;

   reg_idx_t rs1_label;
   reg_idx_t rs2_label;
   reg_idx_t rd_label;
   logic     clear;
   logic     load;

   assign rs1_label = instr_i[19:15];
   assign rs2_label = instr_i[24:20];
   assign rd_label  = ctrl.reg_wr ? instr_i[11:7] : '0;   // No rd without a write

   // Load in EX feeding the instruction in decode
   assign load_stall_o = is_load_o && (rd_o != '0) &&
                         ((rd_o == rs1_label) || (rd_o == rs2_label));

   // Reset, flush and bubble all zero the register
   assign clear = !rst_n_i || flush_i || (!busywait_i && load_stall_o);
   assign load  = !busywait_i && !load_stall_o && !stall_i;

   ////////////////////
   // Register update
   ////////////////////

   always_ff @(posedge clk_i) begin
      if (clear) begin
         pc_o          <= '0;
         rs1_value_o   <= '0;
         rs2_value_o   <= '0;
         imm_value_o   <= '0;
         rs1_label_o   <= '0;
         rs2_label_o   <= '0;
         rd_o          <= '0;
         alu_op_o      <= '0;
         alu_op1_sel_o <= 1'b0;
         alu_op2_sel_o <= 1'b0;
         wb_sel_o      <= '0;
         reg_wr_o      <= 1'b0;
         is_load_o     <= 1'b0;
         is_store_o    <= 1'b0;
         br_op_o       <= '0;
         funct3_o      <= '0;
      end else if (load) begin
         pc_o          <= pc_i;
         rs1_value_o   <= rs1_data_i;
         rs2_value_o   <= rs2_data_i;
         imm_value_o   <= ctrl.imm;
         rs1_label_o   <= rs1_label;
         rs2_label_o   <= rs2_label;
         rd_o          <= rd_label;
         alu_op_o      <= ctrl.alu_op;
         alu_op1_sel_o <= ctrl.op1_sel;
         alu_op2_sel_o <= ctrl.op2_sel;
         wb_sel_o      <= ctrl.wb_sel;
         reg_wr_o      <= ctrl.reg_wr;
         is_load_o     <= ctrl.is_load;
         is_store_o    <= ctrl.is_store;
         br_op_o       <= ctrl.br_op;
         funct3_o      <= ctrl.funct3;
      end
      // Otherwise busywait or stall holds
   end

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  id_pkg::instr_t     instr_i,
   input  id_pkg::pc_t        pc_i,
   input  logic               flush_i,
   input  logic               busywait_i,
   input  logic               stall_i,
   input  id_pkg::reg_idx_t   rd_wr_idx_i,    // From write-back
   input  id_pkg::word_t      rd_wr_data_i,
   output logic               load_stall_o,
   output id_pkg::pc_t        pc_o,
   output id_pkg::word_t      rs1_value_o,
   output id_pkg::word_t      rs2_value_o,
   output id_pkg::word_t      imm_value_o,
   output id_pkg::reg_idx_t   rs1_label_o,
   output id_pkg::reg_idx_t   rs2_label_o,
   output id_pkg::reg_idx_t   rd_o,
   output id_pkg::alu_op_t    alu_op_o,
   output logic               alu_op1_sel_o,
   output logic               alu_op2_sel_o,
   output id_pkg::wb_sel_t    wb_sel_o,
   output logic               reg_wr_o,
   output logic               is_load_o,
   output logic               is_store_o,
   output id_pkg::br_op_t     br_op_o,
   output logic [2:0]         funct3_o
);
   import id_pkg::*;

   word_t rs1_data;
   word_t rs2_data;

   id_ctrl_if ctrl_bus ();   // Decoded control fields

   instr_decoder u_instr_decoder (
      .instr_i (instr_i),
      .ctrl    (ctrl_bus)
   );

   regfile u_regfile (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .rs1_idx_i    (instr_i[19:15]),
      .rs2_idx_i    (instr_i[24:20]),
      .rd_wr_idx_i  (rd_wr_idx_i),
      .rd_wr_data_i (rd_wr_data_i),
      .rs1_data_o   (rs1_data),
      .rs2_data_o   (rs2_data)
   );

   id_ex_register u_id_ex_register (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .flush_i (flush_i), .busywait_i (busywait_i), .stall_i (stall_i),
      .ctrl (ctrl_bus), .instr_i (instr_i), .pc_i (pc_i),
      .rs1_data_i (rs1_data), .rs2_data_i (rs2_data),
      .load_stall_o (load_stall_o), .pc_o (pc_o),
      .rs1_value_o (rs1_value_o), .rs2_value_o (rs2_value_o),
      .imm_value_o (imm_value_o),
      .rs1_label_o (rs1_label_o), .rs2_label_o (rs2_label_o), .rd_o (rd_o),
      .alu_op_o (alu_op_o),
      .alu_op1_sel_o (alu_op1_sel_o), .alu_op2_sel_o (alu_op2_sel_o),
      .wb_sel_o (wb_sel_o), .reg_wr_o (reg_wr_o),
      .is_load_o (is_load_o), .is_store_o (is_store_o),
      .br_op_o (br_op_o), .funct3_o (funct3_o)
   );

endmodule

// File: test/decode_stage_chk.sv
`timescale 1ns/1ps

module decode_stage_chk (
   input logic             clk_i,
   input logic             rst_n_i,
   input logic             flush_i,
   input logic             busywait_i,
   input logic             load_stall_i,
   input id_pkg::instr_t   instr_i,
   input logic [156:0]     ex_state_i,   // Every ID/EX output
   input logic             reg_wr_i,
   input logic             is_load_i,
   input id_pkg::reg_idx_t rd_i
);

   int unsigned fail_count = 0;

   assert property (@(posedge clk_i) (!rst_n_i || flush_i) |=> ex_state_i == '0) else begin
      $error("ID/EX outputs not cleared after reset or flush");
      fail_count++;
   end

   assert property (@(posedge clk_i) (rst_n_i && !flush_i && busywait_i) |=> $stable(ex_state_i))
   else begin
      $error("ID/EX outputs changed under busywait");
      fail_count++;
   end

   // Bubble after a load-use hazard
   assert property (@(posedge clk_i)
      (rst_n_i && !flush_i && !busywait_i && load_stall_i) |=> ex_state_i == '0) else begin
      $error("no bubble after load_stall_o");
      fail_count++;
   end

   assert property (@(posedge clk_i) disable iff (!rst_n_i) !reg_wr_i |-> rd_i == '0) else begin
      $error("rd_o is not zero while reg_wr_o is low");
      fail_count++;
   end

   assert property (@(posedge clk_i) disable iff (!rst_n_i) load_stall_i |->
      is_load_i && rd_i != '0 && (rd_i == instr_i[19:15] || rd_i == instr_i[24:20])) else begin
      $error("load_stall_o without a matching load in EX");
      fail_count++;
   end

endmodule

bind decode_stage decode_stage_chk chk_i (
   .clk_i        (clk_i),
   .rst_n_i      (rst_n_i),
   .flush_i      (flush_i),
   .busywait_i   (busywait_i),
   .load_stall_i (load_stall_o),
   .instr_i      (instr_i),
   .ex_state_i   ({pc_o, rs1_value_o, rs2_value_o, imm_value_o, rs1_label_o, rs2_label_o,
                   rd_o, alu_op_o, alu_op1_sel_o, alu_op2_sel_o, wb_sel_o, reg_wr_o,
                   is_load_o, is_store_o, br_op_o, funct3_o}),
   .reg_wr_i     (reg_wr_o),
   .is_load_i    (is_load_o),
   .rd_i         (rd_o)
);

// File: test/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;
   import id_pkg::*;

   logic       clk_i;
   logic       rst_n_i;
   logic       flush_i;
   logic       busywait_i;
   logic       stall_i;
   instr_t     instr_i;
   pc_t        pc_i;
   reg_idx_t   rd_wr_idx_i;
   word_t      rd_wr_data_i;
   logic       load_stall_o;
   pc_t        pc_o;
   word_t      rs1_value_o, rs2_value_o, imm_value_o;
   reg_idx_t   rs1_label_o, rs2_label_o, rd_o;
   alu_op_t    alu_op_o;
   logic       alu_op1_sel_o, alu_op2_sel_o, reg_wr_o, is_load_o, is_store_o;
   wb_sel_t    wb_sel_o;
   br_op_t     br_op_o;
   logic [2:0] funct3_o;

   word_t        model_regs [32];
   logic [156:0] pend_exp;   // Expected EX state of the last issued instruction
   logic [31:0]  lfsr = 32'hd538b6ea;
   int           checks, errors, base_checks, base_errors, tests;
   alu_op_t      alu_by_f3 [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                   ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
   logic [4:0]   opcodes [10] = '{OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH,
                                  OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, 5'b00011};

   wire [156:0] ex_now = {pc_o, rs1_value_o, rs2_value_o, imm_value_o, rs1_label_o,
                          rs2_label_o, rd_o, alu_op_o, alu_op1_sel_o, alu_op2_sel_o,
                          wb_sel_o, reg_wr_o, is_load_o, is_store_o, br_op_o, funct3_o};

   decode_stage dut_i (.*);

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hb4bc_d35c : lfsr >> 1;   // Galois step
         val  = {val[30:0], lfsr[0]};
      end
      return val;
   endfunction

   function automatic word_t r_type();
      word_t ins;
      ins       = random_bits(25) << 7;
      ins[31]   = 1'b0;
      ins[29:25] = '0;
      ins[6:0]  = 7'b0110011;
      return ins;
   endfunction

   // Reference decode, same field order as ex_now
   function automatic logic [156:0] expect_ex(input word_t ins, input pc_t pc);
      logic [4:0] opc;
      logic [8:0] flags;   // op1, op2, wb, reg_wr, load, store, br
      alu_op_t    alu;
      word_t      imm;
      logic [2:0] f3;
      reg_idx_t   rd;
      opc = ins[6:2];
      case (opc)
         OPC_OP:     flags = {2'b00, WB_ALU, 3'b100, BR_NONE};
         OPC_OP_IMM: flags = {2'b01, WB_ALU, 3'b100, BR_NONE};
         OPC_LOAD:   flags = {2'b01, WB_MEM, 3'b110, BR_NONE};
         OPC_STORE:  flags = {2'b01, WB_ALU, 3'b001, BR_NONE};
         OPC_BRANCH: flags = {2'b11, WB_ALU, 3'b000, BR_COND};
         OPC_LUI:    flags = {2'b01, WB_ALU, 3'b100, BR_NONE};
         OPC_AUIPC:  flags = {2'b11, WB_ALU, 3'b100, BR_NONE};
         OPC_JAL:    flags = {2'b11, WB_PC4, 3'b100, BR_JAL};
         OPC_JALR:   flags = {2'b01, WB_PC4, 3'b100, BR_JALR};
         default:    flags = '0;
      endcase
      case (opc)
         OPC_OP_IMM, OPC_LOAD, OPC_JALR: imm = 32'($signed(ins[31:20]));
         OPC_STORE:  imm = 32'($signed({ins[31:25], ins[11:7]}));
         OPC_BRANCH: imm = 32'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
         OPC_LUI, OPC_AUIPC: imm = {ins[31:12], 12'h000};
         OPC_JAL:    imm = 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
         default:    imm = '0;
      endcase
      alu = (opc == OPC_LUI) ? ALU_PASS_B : ALU_ADD;
      if (opc == OPC_OP || opc == OPC_OP_IMM) begin
         alu = alu_by_f3[ins[14:12]];
         if (ins[30] && ins[14:12] == 3'd5) alu = ALU_SRA;
         if (ins[30] && ins[14:12] == 3'd0 && opc == OPC_OP) alu = ALU_SUB;
      end
      f3 = (flags != '0) ? ins[14:12] : 3'd0;
      rd = flags[4] ? ins[11:7] : 5'd0;
      return {pc, model_regs[ins[19:15]], model_regs[ins[24:20]], imm,
              ins[19:15], ins[24:20], rd, alu, flags, f3};
   endfunction

   task automatic issue(input word_t ins, input reg_idx_t widx, input word_t wdata);
      pc_t pc;
      pc = pc_t'(random_bits(30));
      @(posedge clk_i);
      instr_i      <= ins[31:2];
      pc_i         <= pc;
      rd_wr_idx_i  <= widx;
      rd_wr_data_i <= wdata;
      if (widx != '0) model_regs[widx] = wdata;   // x0 keeps zero
      pend_exp = expect_ex(ins, pc);
   endtask

   task automatic check_ex(input logic [156:0] exp, input string what);
      checks++;
      assert (ex_now === exp) else begin
         $display("mismatch at %0t ns: %s, expected %h, got %h", $time, what, exp, ex_now);
         errors++;
      end
   endtask

   task automatic check_stall(input logic exp, input string what);
      checks++;
      assert (load_stall_o === exp) else begin
         $display("mismatch at %0t ns: %s, expected %b, got %b", $time, what, exp, load_stall_o);
         errors++;
      end
   endtask

   task automatic run_instr(input word_t ins, input reg_idx_t widx, input word_t wdata);
      issue(ins, widx, wdata);
      @(posedge clk_i);
      @(negedge clk_i);
      check_ex(pend_exp, "decoded instruction");
   endtask

   task automatic wait_for_ex(input logic [156:0] exp, input int limit, input string what);
      int n;
      n = 0;
      do begin
         @(negedge clk_i);
         n++;
      end while (ex_now !== exp && n < limit);
      checks++;
      if (ex_now !== exp) begin
         $display("timeout at %0t ns: %s did not appear in %0d cycles", $time, what, limit);
         errors++;
      end
   endtask

   // Load to rd, then a second instruction that may depend on it
   task automatic load_then(input reg_idx_t rd, input word_t dep, input logic stall_exp);
      logic [156:0] dep_exp;
      run_instr({12'h010, 5'd1, 3'b010, rd, 7'b0000011}, '0, '0);
      issue(dep, '0, '0);
      dep_exp = pend_exp;
      @(negedge clk_i);
      check_stall(stall_exp, "load_stall_o after load");
      if (stall_exp) begin
         @(negedge clk_i);
         check_ex('0, "bubble after load-use");
      end
      @(negedge clk_i);
      check_ex(dep_exp, "instruction after load");
   endtask

   task automatic hold_and_release(input logic use_stall);
      logic [156:0] held;
      int n;
      run_instr(r_type(), '0, '0);
      held = pend_exp;
      issue(r_type(), '0, '0);
      n = random_bits(3) + 1;
      if (use_stall) stall_i <= 1'b1;
      else busywait_i <= 1'b1;
      repeat (n) begin
         @(negedge clk_i);
         check_ex(held, "outputs under back-pressure");
      end
      @(posedge clk_i);
      stall_i    <= 1'b0;
      busywait_i <= 1'b0;
      wait_for_ex(pend_exp, 4, "instruction after release");
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %s: %0d checks, %0d errors", name, checks - base_checks,
               errors - base_errors);
      base_checks = checks;
      base_errors = errors;
   endtask

   initial begin
      int total;
      rst_n_i      = 1'b0;
      flush_i      = 1'b0;
      busywait_i   = 1'b0;
      stall_i      = 1'b0;
      instr_i      = '0;
      pc_i         = '0;
      rd_wr_idx_i  = '0;
      rd_wr_data_i = '0;
      foreach (model_regs[i]) model_regs[i] = '0;
      {checks, errors, base_checks, base_errors, tests} = '0;
      repeat (4) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      check_ex('0, "outputs after reset");
      end_test("reset");

      for (int r = 0; r < 32; r++) issue(32'h7f, r[4:0], random_bits(32));   // r = 0 is ignored
      // x0 read while a write to x0 is on the port
      run_instr({7'd0, 5'd9, 5'd0, 3'd0, 5'd1, 7'b0110011}, '0, random_bits(32));
      repeat (16) run_instr(r_type(), '0, '0);
      run_instr({7'd0, 5'd7, 5'd7, 3'd0, 5'd8, 7'b0110011}, 5'd7, random_bits(32));
      end_test("regfile");

      // Unknown opcode between instructions keeps EX free of loads
      for (int k = 0; k < 30; k++) begin
         run_instr((random_bits(25) << 7) | {opcodes[k % 10], 2'b11}, '0, '0);
         run_instr(32'h7f, '0, '0);
      end
      end_test("decode");

      load_then(5'd5, {7'd0, 5'd2, 5'd5, 3'd0, 5'd7, 7'b0110011}, 1'b1);
      load_then(5'd5, {7'd0, 5'd5, 5'd3, 3'd0, 5'd7, 7'b0110011}, 1'b1);
      load_then(5'd0, {7'd0, 5'd0, 5'd0, 3'd0, 5'd3, 7'b0110011}, 1'b0);
      load_then(5'd6, {7'd0, 5'd2, 5'd1, 3'd0, 5'd4, 7'b0110011}, 1'b0);
      end_test("load-use");

      run_instr(r_type(), '0, '0);
      @(posedge clk_i);
      flush_i <= 1'b1;
      @(posedge clk_i);
      flush_i <= 1'b0;
      @(negedge clk_i);
      check_ex('0, "outputs after flush");
      repeat (3) hold_and_release(1'b0);
      repeat (3) hold_and_release(1'b1);
      end_test("back-pressure");

      total = errors + dut_i.chk_i.fail_count;
      $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests, checks,
               errors, dut_i.chk_i.fail_count);
      if (total == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// File: all.f
src/id_pkg.sv
src/id_ctrl_if.sv
src/instr_decoder.sv
src/regfile.sv
src/id_ex_register.sv
src/decode_stage.sv
test/decode_stage_chk.sv
test/tb_decode_stage.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - src/id_pkg.sv
  - src/id_ctrl_if.sv
  - src/instr_decoder.sv
  - src/regfile.sv
  - src/id_ex_register.sv
  - src/decode_stage.sv
  - target: test
    files:
      - test/decode_stage_chk.sv
      - test/tb_decode_stage.sv
